/* tb/board_stimulus.txt */
# master op address(hex) chan data expect; C chan 1 = I/O cycle, D chan = DMA channel
# P: CPU at address and DMA at address[15:0] read at once; K drives io_ch_ck_n; S expect = {nmi, spk}
C W 00010 0 5A 00
C W 00FFF 0 C3 00
C R 00010 0 00 5A
C R 00FFF 0 00 C3
C W 01234 0 77 00
C R 00234 0 00 77
C R 3F234 0 00 77
C W 00082 1 02 00
C W 00083 1 F3 00
D W 00345 2 A5 00
D W 00400 3 96 00
C R 20345 0 00 A5
C R 30400 0 00 96
D R 00345 2 00 A5
C R 40000 0 00 FF
C R 80010 0 00 FF
C W C0000 0 12 00
C R 00020 1 00 FF
C R 00040 1 00 FF
C R 00082 1 00 FF
C R 003F8 1 00 FF
C W 00080 1 04 00
D R 00000 0 00 FF
C W 00061 1 03 00
C R 00061 1 00 03
- S 00000 0 00 01
C W 00061 1 02 00
- S 00000 0 00 00
C W 00061 1 01 00
- S 00000 0 00 00
C W 00061 1 00 00
C R 00062 1 00 00
- K 00000 0 00 00
- K 00000 0 01 00
C R 00062 1 00 40
- S 00000 0 00 00
C W 000A0 1 80 00
- S 00000 0 00 02
C W 00061 1 20 00
- S 00000 0 00 00
C R 00062 1 00 00
C R 00061 1 00 20
C W 00061 1 00 00
- K 00000 0 00 00
- K 00000 0 01 00
- S 00000 0 00 02
C W 000A0 1 00 00
- S 00000 0 00 00
C W 00100 0 3C 00
D W 00101 2 C5 00
C R 00101 0 00 C5
- P 20100 2 00 3C
- P 30400 3 00 96

/* vlog.f */
logic/pc_bus_pkg.sv
logic/bus_arbiter.sv
logic/bus_decoder.sv
logic/system_ram.sv
logic/dma_page_regs.sv
logic/io_ports.sv
logic/pc_system_board.sv
tb/tb_pc_system_board.sv

/* run_sim.sh */
#!/bin/sh
# build the board testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_pc_system_board -o tb_sim
status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "Something failed" sim.log; then
   echo "run_sim: simulation reported errors"
   exit 1
fi
echo "run_sim: simulation clean"

/* tb/tb_pc_system_board.sv */
// ----------------------------------------
// testbench of the board bus core, table driven
// run from the project root, reads tb/board_stimulus.txt
// ----------------------------------------
`timescale 1ns/1ps

module tb_pc_system_board;

   localparam int RAM_ADDR_W = 12;

   logic                             clk = 1'b0;
   logic                             reset_n;
   logic                             cpu_cyc, cpu_stb, cpu_we, cpu_io;
   logic [pc_bus_pkg::ADDR_W-1:0]    cpu_adr;
   logic [pc_bus_pkg::DATA_W-1:0]    cpu_wdat, cpu_rdat;
   logic                             cpu_ack;
   logic                             dma_cyc, dma_stb, dma_we;
   logic [1:0]                       dma_chan;
   logic [pc_bus_pkg::DMA_ADR_W-1:0] dma_adr;
   logic [pc_bus_pkg::DATA_W-1:0]    dma_wdat, dma_rdat;
   logic                             dma_ack;
   logic                             io_ch_ck_n, nmi, speaker;

   // one entry per stimulus line
   logic [7:0]  master_q[$];
   logic [7:0]  op_q[$];
   logic [19:0] adr_q[$];
   logic [1:0]  chan_q[$];
   logic [7:0]  dat_q[$];
   logic [7:0]  exp_q[$];
   int          src_line_q[$];

   int tests       = 0;
   int fails       = 0;
   int ack_clash   = 0;
   int cycles      = 0;
   int cycle_limit = 100;   // raised once the table is loaded

   always #20 clk = ~clk;   // 40 ns period

   pc_system_board #(.RAM_ADDR_W(RAM_ADDR_W)) u_dut (
      .clk(clk), .reset_n(reset_n),
      .cpu_cyc_i(cpu_cyc), .cpu_stb_i(cpu_stb), .cpu_we_i(cpu_we), .cpu_io_i(cpu_io),
      .cpu_adr_i(cpu_adr), .cpu_dat_i(cpu_wdat), .cpu_dat_o(cpu_rdat), .cpu_ack_o(cpu_ack),
      .dma_cyc_i(dma_cyc), .dma_stb_i(dma_stb), .dma_we_i(dma_we), .dma_chan_i(dma_chan),
      .dma_adr_i(dma_adr), .dma_dat_i(dma_wdat), .dma_dat_o(dma_rdat), .dma_ack_o(dma_ack),
      .io_ch_ck_n_i(io_ch_ck_n), .nmi_o(nmi), .speaker_o(speaker)
   );

   // acks are stable mid cycle
   always @(negedge clk) begin
      if (cpu_ack && dma_ack) begin
         $display("cpu_ack_o and dma_ack_o were high in the same cycle");
         ack_clash++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout: the run went past %0d cycles", cycle_limit);
         $display("Something failed");
         $finish;
      end
   end

   task automatic load_stimulus();
      int          fd;
      int          n;
      int          line_no;
      string       line;
      logic [7:0]  m, op;
      logic [31:0] adr, ch, dat, expv;
      fd = $fopen("tb/board_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open tb/board_stimulus.txt");
         fails++;
         return;
      end
      line_no = 0;
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         line_no++;
         if (line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%c %c %h %h %h %h", m, op, adr, ch, dat, expv);
            if (n != 6) begin
               $display("stimulus line %0d could not be read", line_no);
               fails++;
            end else begin
               master_q.push_back(m);
               op_q.push_back(op);
               adr_q.push_back(adr[19:0]);
               chan_q.push_back(ch[1:0]);
               dat_q.push_back(dat[7:0]);
               exp_q.push_back(expv[7:0]);
               src_line_q.push_back(line_no);
            end
         end
      end
      $fclose(fd);
      cycle_limit = 20 * op_q.size() + 100;
   endtask

   // Wishbone classic master, holds the request until ack
   task automatic cpu_cycle(input logic we, input logic io, input logic [19:0] adr,
                            input logic [7:0] wdat, output logic [7:0] rdat);
      logic got_ack;
      got_ack  = 1'b0;
      rdat     = '0;
      cpu_cyc  = 1'b1;
      cpu_stb  = 1'b1;
      cpu_we   = we;
      cpu_io   = io;
      cpu_adr  = adr;
      cpu_wdat = wdat;
      while (!got_ack) begin
         @(negedge clk);
         if (cpu_ack) begin
            got_ack = 1'b1;
            rdat    = cpu_rdat;
         end
      end
      @(posedge clk);
      #1;
      cpu_cyc = 1'b0;
      cpu_stb = 1'b0;
      cpu_we  = 1'b0;
   endtask

   task automatic dma_cycle(input logic we, input logic [1:0] chan, input logic [15:0] adr,
                            input logic [7:0] wdat, output logic [7:0] rdat);
      logic got_ack;
      got_ack  = 1'b0;
      rdat     = '0;
      dma_cyc  = 1'b1;
      dma_stb  = 1'b1;
      dma_we   = we;
      dma_chan = chan;
      dma_adr  = adr;
      dma_wdat = wdat;
      while (!got_ack) begin
         @(negedge clk);
         if (dma_ack) begin
            got_ack = 1'b1;
            rdat    = dma_rdat;
         end
      end
      @(posedge clk);
      #1;
      dma_cyc = 1'b0;
      dma_stb = 1'b0;
      dma_we  = 1'b0;
   endtask

   task automatic run_line(input int i);
      logic [7:0]  cpu_rd, dma_rd;
      logic [19:0] adr;
      logic [1:0]  chan;
      logic [7:0]  expv;
      logic        bad;
      adr  = adr_q[i];
      chan = chan_q[i];
      expv = exp_q[i];
      bad  = 1'b0;
      case (op_q[i])
         "W", "R": begin
            if (master_q[i] == "D") begin
               dma_cycle(op_q[i] == "W", chan, adr[15:0], dat_q[i], dma_rd);
               if (op_q[i] == "R" && dma_rd !== expv) begin
                  $display("[FAIL] line %0d: dma_dat_o = 0x%02h, expected 0x%02h",
                           src_line_q[i], dma_rd, expv);
                  bad = 1'b1;
               end
            end else begin
               cpu_cycle(op_q[i] == "W", chan[0], adr, dat_q[i], cpu_rd);   // chan = io
               if (op_q[i] == "R" && cpu_rd !== expv) begin
                  $display("[FAIL] line %0d: cpu_dat_o = 0x%02h, expected 0x%02h",
                           src_line_q[i], cpu_rd, expv);
                  bad = 1'b1;
               end
            end
         end
         "P": begin
            fork
               cpu_cycle(1'b0, 1'b0, adr, 8'h00, cpu_rd);
               dma_cycle(1'b0, chan, adr[15:0], 8'h00, dma_rd);
            join
            if (cpu_rd !== expv) begin
               $display("[FAIL] line %0d: cpu_dat_o = 0x%02h, expected 0x%02h",
                        src_line_q[i], cpu_rd, expv);
               bad = 1'b1;
            end
            if (dma_rd !== expv) begin
               $display("[FAIL] line %0d: dma_dat_o = 0x%02h, expected 0x%02h",
                        src_line_q[i], dma_rd, expv);
               bad = 1'b1;
            end
         end
         "K": begin
            io_ch_ck_n = dat_q[i][0];
            @(posedge clk);
            #1;
         end
         "S": begin
            @(negedge clk);
            if (nmi !== expv[1]) begin
               $display("[FAIL] line %0d: nmi_o = 0x%0h, expected 0x%0h",
                        src_line_q[i], nmi, expv[1]);
               bad = 1'b1;
            end
            if (speaker !== expv[0]) begin
               $display("[FAIL] line %0d: speaker_o = 0x%0h, expected 0x%0h",
                        src_line_q[i], speaker, expv[0]);
               bad = 1'b1;
            end
            @(posedge clk);
            #1;
         end
         default: begin
            $display("line %0d: unknown operation %c", src_line_q[i], op_q[i]);
            bad = 1'b1;
         end
      endcase
      tests++;
      if (bad)
         fails++;
      $display("line %0d %c %c %05h: %s", src_line_q[i], master_q[i], op_q[i], adr,
               bad ? "fail" : "pass");
   endtask

   initial begin
      reset_n    = 1'b0;
      cpu_cyc    = 1'b0;
      cpu_stb    = 1'b0;
      cpu_we     = 1'b0;
      cpu_io     = 1'b0;
      cpu_adr    = '0;
      cpu_wdat   = '0;
      dma_cyc    = 1'b0;
      dma_stb    = 1'b0;
      dma_we     = 1'b0;
      dma_chan   = '0;
      dma_adr    = '0;
      dma_wdat   = '0;
      io_ch_ck_n = 1'b1;   // no channel check pending
      load_stimulus();
      repeat (3) @(posedge clk);
      #1;
      reset_n = 1'b1;
      for (int i = 0; i < op_q.size(); i++)
         run_line(i);
      fails = fails + ack_clash;
      $display("tests run: %0d, tests failed: %0d, ack clashes: %0d", tests, fails, ack_clash);
      if (fails == 0 && tests > 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* logic/pc_system_board.sv */
// ----------------------------------------
// system board bus core: arbiter, decode and slaves
// CPU and DMA ports are Wishbone classic
// ----------------------------------------
`timescale 1ns/1ps

module pc_system_board #(
   parameter int RAM_ADDR_W = 12
) (
   input  logic                              clk,
   input  logic                              reset_n,
   input  logic                              cpu_cyc_i,
   input  logic                              cpu_stb_i,
   input  logic                              cpu_we_i,
   input  logic                              cpu_io_i,
   input  logic [pc_bus_pkg::ADDR_W-1:0]     cpu_adr_i,
   input  logic [pc_bus_pkg::DATA_W-1:0]     cpu_dat_i,
   output logic [pc_bus_pkg::DATA_W-1:0]     cpu_dat_o,
   output logic                              cpu_ack_o,
   input  logic                              dma_cyc_i,
   input  logic                              dma_stb_i,
   input  logic                              dma_we_i,
   input  logic [1:0]                        dma_chan_i,
   input  logic [pc_bus_pkg::DMA_ADR_W-1:0]  dma_adr_i,
   input  logic [pc_bus_pkg::DATA_W-1:0]     dma_dat_i,
   output logic [pc_bus_pkg::DATA_W-1:0]     dma_dat_o,
   output logic                              dma_ack_o,
   input  logic                              io_ch_ck_n_i,
   output logic                              nmi_o,
   output logic                              speaker_o
);

   logic                          bus_stb, bus_we, bus_io, bus_ack;
   logic [pc_bus_pkg::ADDR_W-1:0] bus_adr;
   logic [pc_bus_pkg::DATA_W-1:0] bus_wdat, bus_rdat;
   logic                          ram_stb, page_stb, ports_stb;
   logic                          ram_ack, page_ack, ports_ack;
   logic [pc_bus_pkg::DATA_W-1:0] ram_rdat, page_rdat, ports_rdat;
   logic [pc_bus_pkg::PAGE_W-1:0] page_q;
   logic [1:0]                    page_chan;

   bus_arbiter u_arbiter (
      .clk(clk), .reset_n(reset_n),
      .cpu_cyc_i(cpu_cyc_i), .cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i),
      .cpu_io_i(cpu_io_i), .cpu_adr_i(cpu_adr_i), .cpu_dat_i(cpu_dat_i),
      .dma_cyc_i(dma_cyc_i), .dma_stb_i(dma_stb_i), .dma_we_i(dma_we_i),
      .dma_chan_i(dma_chan_i), .dma_adr_i(dma_adr_i), .dma_dat_i(dma_dat_i),
      .bus_rdat_i(bus_rdat), .bus_ack_i(bus_ack), .page_q_i(page_q),
      .cpu_dat_o(cpu_dat_o), .cpu_ack_o(cpu_ack_o),
      .dma_dat_o(dma_dat_o), .dma_ack_o(dma_ack_o),
      .bus_stb_o(bus_stb), .bus_we_o(bus_we), .bus_io_o(bus_io),
      .bus_adr_o(bus_adr), .bus_wdat_o(bus_wdat), .page_chan_o(page_chan)
   );

   bus_decoder #(.RAM_ADDR_W(RAM_ADDR_W)) u_decoder (
      .clk(clk), .reset_n(reset_n),
      .bus_stb_i(bus_stb), .bus_io_i(bus_io), .bus_adr_i(bus_adr),
      .ram_rdat_i(ram_rdat), .ram_ack_i(ram_ack),
      .page_rdat_i(page_rdat), .page_ack_i(page_ack),
      .ports_rdat_i(ports_rdat), .ports_ack_i(ports_ack),
      .ram_stb_o(ram_stb), .page_stb_o(page_stb), .ports_stb_o(ports_stb),
      .bus_rdat_o(bus_rdat), .bus_ack_o(bus_ack)
   );

   system_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram (
      .clk(clk), .reset_n(reset_n),
      .stb_i(ram_stb), .we_i(bus_we), .adr_i(bus_adr[RAM_ADDR_W-1:0]),
      .wdat_i(bus_wdat), .rdat_o(ram_rdat), .ack_o(ram_ack)
   );

   dma_page_regs u_page (
      .clk(clk), .reset_n(reset_n),
      .stb_i(page_stb), .we_i(bus_we), .adr_i(bus_adr[1:0]),
      .wdat_i(bus_wdat), .chan_i(page_chan),
      .rdat_o(page_rdat), .ack_o(page_ack), .page_q_o(page_q)
   );

   // bit 7 splits 0xA0 from 0x60, bit 5 is set in both
   io_ports u_ports (
      .clk(clk), .reset_n(reset_n),
      .stb_i(ports_stb), .we_i(bus_we), .nmi_blk_i(bus_adr[7]),
      .ofs_i(bus_adr[1:0]), .wdat_i(bus_wdat), .io_ch_ck_n_i(io_ch_ck_n_i),
      .rdat_o(ports_rdat), .ack_o(ports_ack),
      .nmi_o(nmi_o), .speaker_o(speaker_o)
   );

endmodule

/* logic/io_ports.sv */
// ----------------------------------------
// port B/C, channel check latch and NMI mask
// io_ch_ck_n_i is taken as synchronous to clk
// ----------------------------------------
`timescale 1ns/1ps

module io_ports (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic                          nmi_blk_i,   // high for the 0xA0 block
   input  logic [1:0]                    ofs_i,
   input  logic [pc_bus_pkg::DATA_W-1:0] wdat_i,
   input  logic                          io_ch_ck_n_i,
   output logic [pc_bus_pkg::DATA_W-1:0] rdat_o,
   output logic                          ack_o,
   output logic                          nmi_o,
   output logic                          speaker_o
);

   logic [pc_bus_pkg::DATA_W-1:0] port_b_q;
   logic [pc_bus_pkg::DATA_W-1:0] rdat_q;
   logic [pc_bus_pkg::DATA_W-1:0] rdat_d;
   logic nmi_mask_q;
   logic io_ck_q;   // I/O channel check latch
   logic ack_q;
   logic access;

   assign access = stb_i & ~ack_q;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ack_q      <= 1'b0;
         rdat_q     <= '0;
         port_b_q   <= '0;
         nmi_mask_q <= 1'b0;
         io_ck_q    <= 1'b0;
      end else begin
         ack_q <= access;
         if (access)
            rdat_q <= rdat_d;
         if (access && we_i) begin
            if (nmi_blk_i)
               nmi_mask_q <= wdat_i[7];
            else if (ofs_i == pc_bus_pkg::PORT_B_OFS)
               port_b_q <= wdat_i;
         end
         // pb5 clears and holds the latch off
         if (port_b_q[5])
            io_ck_q <= 1'b0;
         else if (!io_ch_ck_n_i)
            io_ck_q <= 1'b1;
      end
   end

   always_comb begin
      rdat_d = pc_bus_pkg::UNMAPPED_DATA;   // NMI mask and port A
      if (!nmi_blk_i) begin
         if (ofs_i == pc_bus_pkg::PORT_B_OFS)
            rdat_d = port_b_q;
         else if (ofs_i == pc_bus_pkg::PORT_C_OFS)
            rdat_d = {1'b0, io_ck_q, 6'b0};   // switches and timer not modelled
      end
   end

   assign rdat_o    = rdat_q;
   assign ack_o     = ack_q;
   assign nmi_o     = nmi_mask_q & io_ck_q;
   assign speaker_o = port_b_q[0] & port_b_q[1];   // gated by port B alone

endmodule

/* logic/dma_page_regs.sv */
// ----------------------------------------
// DMA page registers, write only from I/O
// register n serves DMA channel n
// ----------------------------------------
`timescale 1ns/1ps

module dma_page_regs (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [1:0]                    adr_i,
   input  logic [pc_bus_pkg::DATA_W-1:0] wdat_i,
   input  logic [1:0]                    chan_i,
   output logic [pc_bus_pkg::DATA_W-1:0] rdat_o,
   output logic                          ack_o,
   output logic [pc_bus_pkg::PAGE_W-1:0] page_q_o
);

   logic [pc_bus_pkg::PAGE_W-1:0] page_q [4];
   logic ack_q;
   logic access;

   assign access = stb_i & ~ack_q;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ack_q <= 1'b0;
         for (int i = 0; i < 4; i++)
            page_q[i] <= '0;
      end else begin
         ack_q <= access;
         if (access && we_i)
            page_q[adr_i] <= wdat_i[pc_bus_pkg::PAGE_W-1:0];   // upper bits dropped
      end
   end

   // register file has no read path on the board
   assign rdat_o = pc_bus_pkg::UNMAPPED_DATA;
   assign ack_o  = ack_q;

   // high address bits during the DMA cycle
   assign page_q_o = page_q[chan_i];

endmodule

/* logic/system_ram.sv */
// ----------------------------------------
// byte-wide RAM with a one cycle ack
// contents are undefined after reset
// ----------------------------------------
`timescale 1ns/1ps

module system_ram #(
   parameter int RAM_ADDR_W = 12
) (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [RAM_ADDR_W-1:0]         adr_i,
   input  logic [pc_bus_pkg::DATA_W-1:0] wdat_i,
   output logic [pc_bus_pkg::DATA_W-1:0] rdat_o,
   output logic                          ack_o
);

   logic [pc_bus_pkg::DATA_W-1:0] mem [2**RAM_ADDR_W];
   logic [pc_bus_pkg::DATA_W-1:0] rdat_q;
   logic ack_q;
   logic access;

   // strobe is still high in the ack cycle
   assign access = stb_i & ~ack_q;

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ack_q  <= 1'b0;
         rdat_q <= '0;
      end else begin
         ack_q <= access;
         if (access)
            rdat_q <= mem[adr_i];   // old data on a write
      end
   end

   always_ff @(posedge clk) begin
      if (access && we_i)
         mem[adr_i] <= wdat_i;
   end

   assign rdat_o = rdat_q;
   assign ack_o  = ack_q;

   // master holds its request through the ack cycle
   a_req_held: assert property (@(posedge clk) disable iff (!reset_n)
      access |=> stb_i && $stable(adr_i) && $stable(we_i))
      else $error("ram request changed before ack");

endmodule

/* logic/bus_decoder.sv */
// ----------------------------------------
// memory and I/O decode with unmapped responder
// RAM must fit in the low 256 KiB
// ----------------------------------------
`timescale 1ns/1ps

module bus_decoder #(
   parameter int RAM_ADDR_W = 12
) (
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          bus_stb_i,
   input  logic                          bus_io_i,
   input  logic [pc_bus_pkg::ADDR_W-1:0] bus_adr_i,
   input  logic [pc_bus_pkg::DATA_W-1:0] ram_rdat_i,
   input  logic                          ram_ack_i,
   input  logic [pc_bus_pkg::DATA_W-1:0] page_rdat_i,
   input  logic                          page_ack_i,
   input  logic [pc_bus_pkg::DATA_W-1:0] ports_rdat_i,
   input  logic                          ports_ack_i,
   output logic                          ram_stb_o,
   output logic                          page_stb_o,
   output logic                          ports_stb_o,
   output logic [pc_bus_pkg::DATA_W-1:0] bus_rdat_o,
   output logic                          bus_ack_o
);

   localparam int RAM_SPACE_W = 18;   // 256 KiB window

   if (RAM_ADDR_W > RAM_SPACE_W) begin : g_ram_size_chk
      $error("RAM_ADDR_W exceeds the 256 KiB RAM window");
   end

   pc_bus_pkg::slave_sel_t sel;
   logic [pc_bus_pkg::IO_BLK_W-1:0] io_blk;
   logic unm_ack_q;

   assign io_blk = bus_adr_i[pc_bus_pkg::IO_ADR_W-1:pc_bus_pkg::IO_BLK_LSB];

   always_comb begin
      sel = pc_bus_pkg::SEL_NONE;
      if (!bus_io_i) begin
         if (bus_adr_i[pc_bus_pkg::ADDR_W-1:RAM_SPACE_W] == '0)
            sel = pc_bus_pkg::SEL_RAM;   // ROM and option space unmapped
      end else begin
         case (io_blk)
            pc_bus_pkg::IO_BLOCK_PAGE: sel = pc_bus_pkg::SEL_PAGE;
            pc_bus_pkg::IO_BLOCK_PPI,
            pc_bus_pkg::IO_BLOCK_NMI:  sel = pc_bus_pkg::SEL_PORTS;
            default:                   sel = pc_bus_pkg::SEL_NONE;
         endcase
      end
   end

   assign ram_stb_o   = bus_stb_i & (sel == pc_bus_pkg::SEL_RAM);
   assign page_stb_o  = bus_stb_i & (sel == pc_bus_pkg::SEL_PAGE);
   assign ports_stb_o = bus_stb_i & (sel == pc_bus_pkg::SEL_PORTS);

   // nothing answers here, so ack it ourselves
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         unm_ack_q <= 1'b0;
      end else begin
         unm_ack_q <= bus_stb_i & (sel == pc_bus_pkg::SEL_NONE) & ~unm_ack_q;
      end
   end

   always_comb begin
      case (sel)
         pc_bus_pkg::SEL_RAM: begin
            bus_rdat_o = ram_rdat_i;
            bus_ack_o  = ram_ack_i;
         end
         pc_bus_pkg::SEL_PAGE: begin
            bus_rdat_o = page_rdat_i;
            bus_ack_o  = page_ack_i;
         end
         pc_bus_pkg::SEL_PORTS: begin
            bus_rdat_o = ports_rdat_i;
            bus_ack_o  = ports_ack_i;
         end
         default: begin
            bus_rdat_o = pc_bus_pkg::UNMAPPED_DATA;
            bus_ack_o  = unm_ack_q;
         end
      endcase
   end

endmodule

/* logic/bus_arbiter.sv */
// ----------------------------------------
// CPU/DMA bus arbiter with Wishbone classic on both sides
// DMA always enters through one hold cycle
// a master keeps the bus while its cyc stays high
// ----------------------------------------
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                              clk,
   input  logic                              reset_n,
   input  logic                              cpu_cyc_i,
   input  logic                              cpu_stb_i,
   input  logic                              cpu_we_i,
   input  logic                              cpu_io_i,
   input  logic [pc_bus_pkg::ADDR_W-1:0]     cpu_adr_i,
   input  logic [pc_bus_pkg::DATA_W-1:0]     cpu_dat_i,
   input  logic                              dma_cyc_i,
   input  logic                              dma_stb_i,
   input  logic                              dma_we_i,
   input  logic [1:0]                        dma_chan_i,
   input  logic [pc_bus_pkg::DMA_ADR_W-1:0]  dma_adr_i,
   input  logic [pc_bus_pkg::DATA_W-1:0]     dma_dat_i,
   input  logic [pc_bus_pkg::DATA_W-1:0]     bus_rdat_i,
   input  logic                              bus_ack_i,
   input  logic [pc_bus_pkg::PAGE_W-1:0]     page_q_i,
   output logic [pc_bus_pkg::DATA_W-1:0]     cpu_dat_o,
   output logic                              cpu_ack_o,
   output logic [pc_bus_pkg::DATA_W-1:0]     dma_dat_o,
   output logic                              dma_ack_o,
   output logic                              bus_stb_o,
   output logic                              bus_we_o,
   output logic                              bus_io_o,
   output logic [pc_bus_pkg::ADDR_W-1:0]     bus_adr_o,
   output logic [pc_bus_pkg::DATA_W-1:0]     bus_wdat_o,
   output logic [1:0]                        page_chan_o
);

   pc_bus_pkg::arb_state_t state_q, state_d;
   logic cpu_req, dma_req;
   logic cpu_gnt, dma_gnt;   // dma_gnt doubles as AEN

   assign cpu_req = cpu_cyc_i & cpu_stb_i;
   assign dma_req = dma_cyc_i & dma_stb_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         pc_bus_pkg::ARB_IDLE: begin
            if (cpu_req)
               state_d = pc_bus_pkg::ARB_CPU;   // CPU wins a tie
            else if (dma_req)
               state_d = pc_bus_pkg::ARB_HOLD;
         end
         pc_bus_pkg::ARB_CPU: begin
            // hold request is only honoured between CPU cycles
            if (!cpu_cyc_i)
               state_d = dma_req ? pc_bus_pkg::ARB_HOLD : pc_bus_pkg::ARB_IDLE;
         end
         pc_bus_pkg::ARB_HOLD: state_d = pc_bus_pkg::ARB_DMA;
         pc_bus_pkg::ARB_DMA: begin
            if (!dma_cyc_i)
               state_d = pc_bus_pkg::ARB_IDLE;
         end
         default: state_d = pc_bus_pkg::ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state_q <= pc_bus_pkg::ARB_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign cpu_gnt = (state_q == pc_bus_pkg::ARB_CPU);
   assign dma_gnt = (state_q == pc_bus_pkg::ARB_DMA);

   // granted master onto the system bus
   assign bus_stb_o  = (cpu_gnt & cpu_req) | (dma_gnt & dma_req);
   assign bus_we_o   = dma_gnt ? dma_we_i : cpu_we_i;
   assign bus_io_o   = cpu_gnt & cpu_io_i;   // DMA runs memory cycles only
   assign bus_adr_o  = dma_gnt ? {page_q_i, dma_adr_i} : cpu_adr_i;
   assign bus_wdat_o = dma_gnt ? dma_dat_i : cpu_dat_i;
   assign page_chan_o = dma_chan_i;

   // response goes back to the owner only
   assign cpu_dat_o = bus_rdat_i;
   assign dma_dat_o = bus_rdat_i;
   assign cpu_ack_o = cpu_gnt & bus_ack_i;
   assign dma_ack_o = dma_gnt & bus_ack_i;

   // every slave answers one cycle after the strobe
   a_ack_latency: assert property (@(posedge clk) disable iff (!reset_n)
      bus_stb_o && !bus_ack_i |=> bus_ack_i)
      else $error("bus ack missing one cycle after bus strobe");

   // a slave ack with no strobe means a stale or stray response
   a_ack_in_cycle: assert property (@(posedge clk) disable iff (!reset_n)
      bus_ack_i |-> bus_stb_o)
      else $error("bus ack without bus strobe");

endmodule

/* logic/pc_bus_pkg.sv */
// ----------------------------------------
// shared widths, I/O map and enums of the board bus
// I/O decode uses 10 address bits, as on the board
// ----------------------------------------
package pc_bus_pkg;

   parameter int ADDR_W    = 20;   // system address
   parameter int DATA_W    = 8;
   parameter int DMA_ADR_W = 16;   // DMA offset within a 64 KiB page
   parameter int PAGE_W    = 4;    // page register, address bits 19:16
   parameter int IO_ADR_W  = 10;   // decoded I/O address

   // 32-port I/O blocks on address bits 9:5
   parameter int IO_BLK_LSB = 5;
   parameter int IO_BLK_W   = IO_ADR_W - IO_BLK_LSB;

   parameter logic [IO_BLK_W-1:0] IO_BLOCK_PPI  = 5'd3;   // 0x60
   parameter logic [IO_BLK_W-1:0] IO_BLOCK_PAGE = 5'd4;   // 0x80
   parameter logic [IO_BLK_W-1:0] IO_BLOCK_NMI  = 5'd5;   // 0xA0

   // offsets within the PPI block
   parameter logic [1:0] PORT_B_OFS = 2'd1;   // 0x61
   parameter logic [1:0] PORT_C_OFS = 2'd2;   // 0x62

   // floating data bus reads as all ones
   parameter logic [DATA_W-1:0] UNMAPPED_DATA = 8'hFF;

   // hold request / hold acknowledge sequence
   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,   // nobody owns the bus
      ARB_CPU  = 2'd1,
      ARB_HOLD = 2'd2,   // hold acknowledged, AEN switching
      ARB_DMA  = 2'd3
   } arb_state_t;

   // decoded target of the current bus cycle
   typedef enum logic [1:0] {
      SEL_NONE  = 2'd0,   // unmapped responder
      SEL_RAM   = 2'd1,
      SEL_PAGE  = 2'd2,
      SEL_PORTS = 2'd3
   } slave_sel_t;

endpackage
